// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/regfile.sv
  - hdl/id_stage.sv
  - hdl/ex_stage.sv
  - hdl/wb_stage.sv
  - hdl/rv_core_top.sv
  - target: test
    files:
      - sim/rv_core_tb.sv

// ==== hdl/ex_stage.sv ====
module ex_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            ex_valid,
  input  logic [rv_pkg::xlen-1:0]         ex_pc,
  input  logic [rv_pkg::xlen-1:0]         ex_op1,
  input  logic [rv_pkg::xlen-1:0]         ex_op2,
  input  logic [rv_pkg::xlen-1:0]         ex_rs1_data,
  input  logic [rv_pkg::xlen-1:0]         ex_rs2_data,
  input  logic [rv_pkg::xlen-1:0]         ex_imm,
  input  rv_pkg::alu_op_t                 ex_alu_op,
  input  rv_pkg::bj_op_t                  ex_bj_op,
  input  logic                            ex_is_word,
  input  logic                            ex_use_rs1,
  input  logic                            ex_use_rs2,
  input  logic [rv_pkg::reg_addr_w-1:0]   ex_rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0]   ex_rs2_addr,
  input  logic                            ex_rd_wr,
  input  logic [rv_pkg::reg_addr_w-1:0]   ex_rd_addr,
  input  logic                            ex_illegal,
  output logic                            wb_valid,
  output logic [rv_pkg::xlen-1:0]         wb_pc,
  output logic                            wb_rd_wr,
  output logic [rv_pkg::reg_addr_w-1:0]   wb_rd_addr,
  output logic [rv_pkg::xlen-1:0]         wb_result,
  output logic                            wb_illegal,
  output logic                            wb_br_taken,
  output logic [rv_pkg::xlen-1:0]         wb_br_target
);

  logic                    fwd1, fwd2;
  logic [rv_pkg::xlen-1:0] rs1_fwd, rs2_fwd;
  logic [rv_pkg::xlen-1:0] alu_a, alu_b, alu_d, alu_res;
  logic [rv_pkg::xlen-1:0] jalr_sum, target;
  logic [31:0]             alu_w;
  logic [5:0]              shamt;
  logic                    eq, lt, ltu, taken;

  // previous instruction sits in the wb registers
  assign fwd1 = ex_use_rs1 && wb_valid && wb_rd_wr && (wb_rd_addr == ex_rs1_addr);
  assign fwd2 = ex_use_rs2 && wb_valid && wb_rd_wr && (wb_rd_addr == ex_rs2_addr);

  assign rs1_fwd = fwd1 ? wb_result : ex_rs1_data;
  assign rs2_fwd = fwd2 ? wb_result : ex_rs2_data;

  // jalr reads rs1 for the target but links from pc
  assign alu_a = (ex_use_rs1 && ex_bj_op != rv_pkg::bj_jalr) ? rs1_fwd : ex_op1;
  assign alu_b = ex_use_rs2 ? rs2_fwd : ex_op2;
  assign shamt = alu_b[5:0];

  always_comb begin
    case (ex_alu_op)
      rv_pkg::alu_sub:  alu_d = alu_a - alu_b;
      rv_pkg::alu_slt:  alu_d = {{(rv_pkg::xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      rv_pkg::alu_sltu: alu_d = {{(rv_pkg::xlen-1){1'b0}}, alu_a < alu_b};
      rv_pkg::alu_xor:  alu_d = alu_a ^ alu_b;
      rv_pkg::alu_or:   alu_d = alu_a | alu_b;
      rv_pkg::alu_and:  alu_d = alu_a & alu_b;
      rv_pkg::alu_sll:  alu_d = alu_a << shamt;
      rv_pkg::alu_srl:  alu_d = alu_a >> shamt;
      rv_pkg::alu_sra:  alu_d = $signed(alu_a) >>> shamt;
      default:          alu_d = alu_a + alu_b;
    endcase
  end

  // word forms, 5-bit shift amount
  always_comb begin
    case (ex_alu_op)
      rv_pkg::alu_sub: alu_w = alu_a[31:0] - alu_b[31:0];
      rv_pkg::alu_sll: alu_w = alu_a[31:0] << shamt[4:0];
      rv_pkg::alu_srl: alu_w = alu_a[31:0] >> shamt[4:0];
      rv_pkg::alu_sra: alu_w = $signed(alu_a[31:0]) >>> shamt[4:0];
      default:         alu_w = alu_a[31:0] + alu_b[31:0];
    endcase
  end

  assign alu_res = ex_is_word ? {{32{alu_w[31]}}, alu_w} : alu_d;

  assign eq  = (rs1_fwd == rs2_fwd);
  assign lt  = $signed(rs1_fwd) < $signed(rs2_fwd);
  assign ltu = rs1_fwd < rs2_fwd;

  always_comb begin
    case (ex_bj_op)
      rv_pkg::bj_beq:  taken = eq;
      rv_pkg::bj_bne:  taken = !eq;
      rv_pkg::bj_blt:  taken = lt;
      rv_pkg::bj_bge:  taken = !lt;
      rv_pkg::bj_bltu: taken = ltu;
      rv_pkg::bj_bgeu: taken = !ltu;
      rv_pkg::bj_jal:  taken = 1'b1;
      rv_pkg::bj_jalr: taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_fwd + ex_imm;
  assign target   = (ex_bj_op == rv_pkg::bj_jalr) ? {jalr_sum[rv_pkg::xlen-1:1], 1'b0}
                                                  : ex_pc + ex_imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid    <= 1'b0;
      wb_rd_wr    <= 1'b0;
      wb_illegal  <= 1'b0;
      wb_br_taken <= 1'b0;
    end else begin
      wb_valid    <= ex_valid;
      wb_rd_wr    <= ex_valid && ex_rd_wr;
      wb_illegal  <= ex_valid && ex_illegal;
      wb_br_taken <= ex_valid && taken;
    end
  end

  always_ff @(posedge clk) begin
    wb_pc        <= ex_pc;
    wb_rd_addr   <= ex_rd_addr;
    wb_result    <= alu_res;
    wb_br_target <= target;
  end

  // decoder must never mark a conditional branch as writing rd
  assert property (@(posedge clk) disable iff (rst)
    ex_valid && (ex_bj_op inside {rv_pkg::bj_beq, rv_pkg::bj_bne, rv_pkg::bj_blt,
                                  rv_pkg::bj_bge, rv_pkg::bj_bltu, rv_pkg::bj_bgeu})
    |-> !ex_rd_wr);

endmodule

// ==== hdl/id_stage.sv ====
module id_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  input  logic [31:0]                     inst,
  input  logic [rv_pkg::xlen-1:0]         pc,
  output logic [rv_pkg::reg_addr_w-1:0]   rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0]   rs2_addr,
  input  logic [rv_pkg::xlen-1:0]         rs1_data,
  input  logic [rv_pkg::xlen-1:0]         rs2_data,
  output logic                            ex_valid,
  output logic [rv_pkg::xlen-1:0]         ex_pc,
  output logic [rv_pkg::xlen-1:0]         ex_op1,
  output logic [rv_pkg::xlen-1:0]         ex_op2,
  output logic [rv_pkg::xlen-1:0]         ex_rs1_data,
  output logic [rv_pkg::xlen-1:0]         ex_rs2_data,
  output logic [rv_pkg::xlen-1:0]         ex_imm,
  output rv_pkg::alu_op_t                 ex_alu_op,
  output rv_pkg::bj_op_t                  ex_bj_op,
  output logic                            ex_is_word,
  output logic                            ex_use_rs1,
  output logic                            ex_use_rs2,
  output logic [rv_pkg::reg_addr_w-1:0]   ex_rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0]   ex_rs2_addr,
  output logic                            ex_rd_wr,
  output logic [rv_pkg::reg_addr_w-1:0]   ex_rd_addr,
  output logic                            ex_illegal
);

  logic [6:0]                    opcode;
  logic [2:0]                    func3;
  logic [5:0]                    func6;
  logic [6:0]                    func7;
  logic [rv_pkg::reg_addr_w-1:0] rd_addr;
  logic [rv_pkg::xlen-1:0]       imm_i, imm_u, imm_b, imm_j;
  logic [rv_pkg::xlen-1:0]       op1, op2, imm;
  logic                          legal, use_rs1, use_rs2, rd_wr, is_word;
  rv_pkg::alu_op_t               arith_op, alu_op;
  rv_pkg::bj_op_t                bj_op;

  assign opcode  = inst[6:0];
  assign func3   = inst[14:12];
  assign func6   = inst[31:26];
  assign func7   = inst[31:25];
  assign rd_addr = inst[11:7];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // sub only exists in the register forms (opcode bit 5)
  always_comb begin
    case (func3)
      3'd0:    arith_op = (opcode[5] && inst[30]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'd1:    arith_op = rv_pkg::alu_sll;
      3'd2:    arith_op = rv_pkg::alu_slt;
      3'd3:    arith_op = rv_pkg::alu_sltu;
      3'd4:    arith_op = rv_pkg::alu_xor;
      3'd5:    arith_op = inst[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'd6:    arith_op = rv_pkg::alu_or;
      default: arith_op = rv_pkg::alu_and;
    endcase
  end

  always_comb begin
    legal   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    rd_wr   = 1'b0;
    is_word = 1'b0;
    alu_op  = rv_pkg::alu_add;
    bj_op   = rv_pkg::bj_none;
    op1     = rs1_data;
    op2     = rs2_data;
    imm     = imm_i;
    case (opcode)
      rv_pkg::op_lui: begin
        legal = 1'b1;
        rd_wr = 1'b1;
        op1   = '0;
        op2   = imm_u;
      end
      rv_pkg::op_auipc: begin
        legal = 1'b1;
        rd_wr = 1'b1;
        op1   = pc;
        op2   = imm_u;
      end
      // jumps link pc+4 through the adder
      rv_pkg::op_jal: begin
        legal = 1'b1;
        rd_wr = 1'b1;
        op1   = pc;
        op2   = 64'd4;
        bj_op = rv_pkg::bj_jal;
        imm   = imm_j;
      end
      rv_pkg::op_jalr: begin
        legal   = (func3 == 3'd0);
        use_rs1 = 1'b1;
        rd_wr   = 1'b1;
        op1     = pc;
        op2     = 64'd4;
        bj_op   = rv_pkg::bj_jalr;
      end
      rv_pkg::op_branch: begin
        legal   = (func3 != 3'd2) && (func3 != 3'd3);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        alu_op  = rv_pkg::alu_sub;
        imm     = imm_b;
        case (func3)
          3'd0:    bj_op = rv_pkg::bj_beq;
          3'd1:    bj_op = rv_pkg::bj_bne;
          3'd4:    bj_op = rv_pkg::bj_blt;
          3'd5:    bj_op = rv_pkg::bj_bge;
          3'd6:    bj_op = rv_pkg::bj_bltu;
          3'd7:    bj_op = rv_pkg::bj_bgeu;
          default: bj_op = rv_pkg::bj_none;
        endcase
      end
      rv_pkg::op_imm: begin
        legal   = (func3 == 3'd1) ? (func6 == 6'h00) :
                  (func3 == 3'd5) ? (func6 == 6'h00 || func6 == 6'h10) : 1'b1;
        use_rs1 = 1'b1;
        rd_wr   = 1'b1;
        alu_op  = arith_op;
        op2     = imm_i;
      end
      rv_pkg::op_imm_w: begin
        legal   = (func3 == 3'd0) || (func3 == 3'd1 && func7 == 7'h00)
                || (func3 == 3'd5 && (func7 == 7'h00 || func7 == 7'h20));
        use_rs1 = 1'b1;
        rd_wr   = 1'b1;
        is_word = 1'b1;
        alu_op  = arith_op;
        op2     = imm_i;
      end
      rv_pkg::op_reg: begin
        legal   = (func7 == 7'h00) || (func7 == 7'h20 && (func3 == 3'd0 || func3 == 3'd5));
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        rd_wr   = 1'b1;
        alu_op  = arith_op;
      end
      rv_pkg::op_reg_w: begin
        legal   = (func3 == 3'd0 || func3 == 3'd1 || func3 == 3'd5)
                && (func7 == 7'h00 || (func7 == 7'h20 && func3 != 3'd1));
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        rd_wr   = 1'b1;
        is_word = 1'b1;
        alu_op  = arith_op;
      end
      default: legal = 1'b0;
    endcase
  end

  assign rs1_addr = use_rs1 ? inst[19:15] : '0;
  assign rs2_addr = use_rs2 ? inst[24:20] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid   <= 1'b0;
      ex_rd_wr   <= 1'b0;
      ex_illegal <= 1'b0;
      ex_bj_op   <= rv_pkg::bj_none;
    end else begin
      ex_valid   <= in_valid;
      // x0 writes are dropped here
      ex_rd_wr   <= in_valid && legal && rd_wr && (rd_addr != '0);
      ex_illegal <= in_valid && !legal;
      ex_bj_op   <= (in_valid && legal) ? bj_op : rv_pkg::bj_none;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc       <= pc;
    ex_op1      <= op1;
    ex_op2      <= op2;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= imm;
    ex_alu_op   <= alu_op;
    ex_is_word  <= is_word;
    ex_use_rs1  <= use_rs1;
    ex_use_rs2  <= use_rs2;
    ex_rs1_addr <= rs1_addr;
    ex_rs2_addr <= rs2_addr;
    ex_rd_addr  <= rd_addr;
  end

  assert property (@(posedge clk) disable iff (rst) !(ex_rd_wr && ex_illegal));

endmodule

// ==== hdl/regfile.sv ====
module regfile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [rv_pkg::reg_addr_w-1:0]   rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0]   rs2_addr,
  output logic [rv_pkg::xlen-1:0]         rs1_data,
  output logic [rv_pkg::xlen-1:0]         rs2_data,
  input  logic                            rf_wr_ena,
  input  logic [rv_pkg::reg_addr_w-1:0]   rf_wr_addr,
  input  logic [rv_pkg::xlen-1:0]         rf_wr_data
);

  logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**rv_pkg::reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_wr_ena && rf_wr_addr != '0) begin
      regs[rf_wr_addr] <= rf_wr_data;
    end
  end

  // write-through covers the producer two slots ahead
  always_comb begin
    if (rs1_addr == '0)
      rs1_data = '0;
    else if (rf_wr_ena && rf_wr_addr == rs1_addr)
      rs1_data = rf_wr_data;
    else
      rs1_data = regs[rs1_addr];
    if (rs2_addr == '0)
      rs2_data = '0;
    else if (rf_wr_ena && rf_wr_addr == rs2_addr)
      rs2_data = rf_wr_data;
    else
      rs2_data = regs[rs2_addr];
  end

endmodule

// ==== hdl/rv_core_top.sv ====
module rv_core_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  input  logic [31:0]                     inst,
  input  logic [rv_pkg::xlen-1:0]         pc,
  output logic                            retire_valid,
  output logic [rv_pkg::xlen-1:0]         retire_pc,
  output logic                            retire_illegal,
  output logic                            retire_rd_wr,
  output logic [rv_pkg::reg_addr_w-1:0]   retire_rd,
  output logic [rv_pkg::xlen-1:0]         retire_data,
  output logic                            branch_taken,
  output logic [rv_pkg::xlen-1:0]         branch_target,
  output logic [63:0]                     instret
);

  logic [rv_pkg::reg_addr_w-1:0] rs1_addr, rs2_addr;
  logic [rv_pkg::xlen-1:0]       rs1_data, rs2_data;

  logic                          ex_valid, ex_is_word, ex_use_rs1, ex_use_rs2;
  logic                          ex_rd_wr, ex_illegal;
  logic [rv_pkg::xlen-1:0]       ex_pc, ex_op1, ex_op2, ex_rs1_data, ex_rs2_data, ex_imm;
  logic [rv_pkg::reg_addr_w-1:0] ex_rs1_addr, ex_rs2_addr, ex_rd_addr;
  rv_pkg::alu_op_t               ex_alu_op;
  rv_pkg::bj_op_t                ex_bj_op;

  logic                          wb_valid, wb_rd_wr, wb_illegal, wb_br_taken;
  logic [rv_pkg::xlen-1:0]       wb_pc, wb_result, wb_br_target;
  logic [rv_pkg::reg_addr_w-1:0] wb_rd_addr;

  logic                          rf_wr_ena;
  logic [rv_pkg::reg_addr_w-1:0] rf_wr_addr;
  logic [rv_pkg::xlen-1:0]       rf_wr_data;

  id_stage u_id_stage (.*);

  regfile u_regfile (.*);

  ex_stage u_ex_stage (.*);

  wb_stage u_wb_stage (.*);

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;

  // rv64i major opcodes
  localparam logic [6:0] op_lui    = 7'h37;
  localparam logic [6:0] op_auipc  = 7'h17;
  localparam logic [6:0] op_jal    = 7'h6f;
  localparam logic [6:0] op_jalr   = 7'h67;
  localparam logic [6:0] op_branch = 7'h63;
  localparam logic [6:0] op_imm    = 7'h13;
  localparam logic [6:0] op_imm_w  = 7'h1b;
  localparam logic [6:0] op_reg    = 7'h33;
  localparam logic [6:0] op_reg_w  = 7'h3b;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_slt  = 4'd2,
    alu_sltu = 4'd3,
    alu_xor  = 4'd4,
    alu_or   = 4'd5,
    alu_and  = 4'd6,
    alu_sll  = 4'd7,
    alu_srl  = 4'd8,
    alu_sra  = 4'd9
  } alu_op_t;

  // bj_none for everything that never redirects
  typedef enum logic [3:0] {
    bj_none = 4'd0,
    bj_beq  = 4'd1,
    bj_bne  = 4'd2,
    bj_blt  = 4'd3,
    bj_bge  = 4'd4,
    bj_bltu = 4'd5,
    bj_bgeu = 4'd6,
    bj_jal  = 4'd7,
    bj_jalr = 4'd8
  } bj_op_t;

endpackage

// ==== hdl/wb_stage.sv ====
module wb_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            wb_valid,
  input  logic [rv_pkg::xlen-1:0]         wb_pc,
  input  logic                            wb_rd_wr,
  input  logic [rv_pkg::reg_addr_w-1:0]   wb_rd_addr,
  input  logic [rv_pkg::xlen-1:0]         wb_result,
  input  logic                            wb_illegal,
  input  logic                            wb_br_taken,
  input  logic [rv_pkg::xlen-1:0]         wb_br_target,
  output logic                            rf_wr_ena,
  output logic [rv_pkg::reg_addr_w-1:0]   rf_wr_addr,
  output logic [rv_pkg::xlen-1:0]         rf_wr_data,
  output logic                            retire_valid,
  output logic [rv_pkg::xlen-1:0]         retire_pc,
  output logic                            retire_illegal,
  output logic                            retire_rd_wr,
  output logic [rv_pkg::reg_addr_w-1:0]   retire_rd,
  output logic [rv_pkg::xlen-1:0]         retire_data,
  output logic                            branch_taken,
  output logic [rv_pkg::xlen-1:0]         branch_target,
  output logic [63:0]                     instret
);

  assign rf_wr_ena  = wb_valid && wb_rd_wr;
  assign rf_wr_addr = wb_rd_addr;
  assign rf_wr_data = wb_result;

  assign retire_valid   = wb_valid;
  assign retire_pc      = wb_pc;
  assign retire_illegal = wb_illegal;
  assign retire_rd_wr   = rf_wr_ena;
  assign retire_rd      = wb_rd_addr;
  assign retire_data    = wb_result;
  assign branch_taken   = wb_br_taken;
  assign branch_target  = wb_br_target;

  // counts illegal retirements too
  always_ff @(posedge clk) begin
    if (rst)
      instret <= '0;
    else if (wb_valid)
      instret <= instret + 64'd1;
  end

  assert property (@(posedge clk) disable iff (rst) rf_wr_ena |-> rf_wr_addr != '0);

endmodule

// ==== rv_core_top.f ====
hdl/rv_pkg.sv
hdl/regfile.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/wb_stage.sv
hdl/rv_core_top.sv
sim/rv_core_tb.sv

// ==== sim/rv_core_tb.sv ====
module rv_core_tb;

  localparam int          n_inst     = 400;
  localparam int          clk_period = 20;
  localparam logic [31:0] seed       = 32'hf0f4_2618;

  typedef struct packed {
    logic [31:0] cyc;
    logic [63:0] pc;
    logic        illegal;
    logic        rd_wr;
    logic [4:0]  rd;
    logic [63:0] data;
    logic        taken;
    logic [63:0] target;
  } exp_t;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic [31:0] inst;
  logic [63:0] pc;
  logic        retire_valid;
  logic [63:0] retire_pc;
  logic        retire_illegal;
  logic        retire_rd_wr;
  logic [4:0]  retire_rd;
  logic [63:0] retire_data;
  logic        branch_taken;
  logic [63:0] branch_target;
  logic [63:0] instret;

  logic [31:0] rng_state;
  logic [63:0] model_rf [32];
  exp_t        exp_q [$];
  exp_t        head;
  exp_t        issued;
  int          cycle = 0;
  int          n_retired = 0;

  rv_core_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_eq(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // alt selects sub or arithmetic shift
  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic word, input logic [63:0] x,
                                          input logic [63:0] y);
    logic [31:0] w;
    logic [63:0] r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[5:0];
      3'd2: r = {63'd0, $signed(x) < $signed(y)};
      3'd3: r = {63'd0, x < y};
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt)
          r = $signed(x) >>> y[5:0];
        else
          r = x >> y[5:0];
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    if (word) begin
      case (f3)
        3'd1: w = x[31:0] << y[4:0];
        3'd5: begin
          if (alt)
            w = $signed(x[31:0]) >>> y[4:0];
          else
            w = x[31:0] >> y[4:0];
        end
        default: w = r[31:0];
      endcase
      r = {{32{w[31]}}, w};
    end
    return r;
  endfunction

  // in-order ISA model, updates model_rf
  function automatic exp_t execute_ref(input logic [31:0] ins, input logic [63:0] ipc);
    exp_t        e;
    logic [2:0]  f3;
    logic [63:0] a, b, imm_i, imm_u, imm_b, imm_j, res;
    logic        legal, wr;
    f3    = ins[14:12];
    a     = model_rf[ins[19:15]];
    b     = model_rf[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
    imm_b = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    e     = '0;
    e.pc  = ipc;
    e.rd  = ins[11:7];
    legal = 1'b1;
    wr    = 1'b1;
    res   = '0;
    case (ins[6:0])
      rv_pkg::op_lui:   res = imm_u;
      rv_pkg::op_auipc: res = ipc + imm_u;
      rv_pkg::op_jal: begin
        res      = ipc + 64'd4;
        e.taken  = 1'b1;
        e.target = ipc + imm_j;
      end
      rv_pkg::op_jalr: begin
        res      = ipc + 64'd4;
        e.taken  = 1'b1;
        e.target = (a + imm_i) & ~64'd1;
      end
      rv_pkg::op_branch: begin
        wr       = 1'b0;
        e.target = ipc + imm_b;
        case (f3)
          3'd0:    e.taken = (a == b);
          3'd1:    e.taken = (a != b);
          3'd4:    e.taken = ($signed(a) < $signed(b));
          3'd5:    e.taken = ($signed(a) >= $signed(b));
          3'd6:    e.taken = (a < b);
          3'd7:    e.taken = (a >= b);
          default: legal = 1'b0;
        endcase
      end
      rv_pkg::op_imm:   res = alu_ref(f3, f3 == 3'd5 && ins[30], 1'b0, a, imm_i);
      rv_pkg::op_imm_w: res = alu_ref(f3, f3 == 3'd5 && ins[30], 1'b1, a, imm_i);
      rv_pkg::op_reg:   res = alu_ref(f3, ins[30], 1'b0, a, b);
      rv_pkg::op_reg_w: res = alu_ref(f3, ins[30], 1'b1, a, b);
      default:          legal = 1'b0;
    endcase
    if (!legal) begin
      e.illegal = 1'b1;
      e.taken   = 1'b0;
      wr        = 1'b0;
    end
    e.rd_wr = wr && (e.rd != 5'd0);
    e.data  = res;
    if (e.rd_wr)
      model_rf[e.rd] = res;
    return e;
  endfunction

  // small_regs narrows indices to x0..x7 for dense dependencies
  function automatic logic [31:0] make_inst(input logic small_regs);
    logic [31:0] r, ins;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3, wf3;
    r   = xorshift32();
    ins = xorshift32();
    rd  = small_regs ? {2'b00, r[2:0]} : r[4:0];
    rs1 = small_regs ? {2'b00, r[7:5]} : r[9:5];
    rs2 = small_regs ? {2'b00, r[12:10]} : r[14:10];
    f3  = r[17:15];
    wf3 = (f3[1:0] == 2'd1) ? 3'd1 : ((f3[1:0] == 2'd2) ? 3'd5 : 3'd0);
    case (r[27:20] % 9)
      0: ins = {ins[31:12], rd, r[18] ? rv_pkg::op_lui : rv_pkg::op_auipc};
      1: ins = {ins[31:12], rd, rv_pkg::op_jal};
      2: ins = {ins[31:20], rs1, 3'd0, rd, rv_pkg::op_jalr};
      3: ins = {ins[31:25], rs2, rs1, f3 | {f3[1], 2'b00}, ins[11:7], rv_pkg::op_branch};
      4: begin
        ins = {ins[31:20], rs1, f3, rd, rv_pkg::op_imm};
        if (f3[1:0] == 2'b01)
          ins[31:26] = {1'b0, f3[2] & r[18], 4'b0};
      end
      5: begin
        ins = {ins[31:20], rs1, wf3, rd, rv_pkg::op_imm_w};
        if (wf3 != 3'd0)
          ins[31:25] = {1'b0, wf3[2] & r[18], 5'b0};
      end
      6: ins = {1'b0, r[18] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd,
                rv_pkg::op_reg};
      7: ins = {1'b0, r[18] && (wf3 != 3'd1), 5'b0, rs2, rs1, wf3, rd, rv_pkg::op_reg_w};
      // load, store, fence, system
      default: ins[6:0] = r[19] ? (r[18] ? 7'h73 : 7'h0f) : (r[18] ? 7'h23 : 7'h03);
    endcase
    return ins;
  endfunction

  initial begin
    #((n_inst + 100) * clk_period);
    $display("timeout: not all instructions retired in time");
    $display("Test failed");
    $fatal(1);
  end

  always @(negedge clk) begin
    if (!rst) begin
      check_eq(instret, n_retired, "instret");
      if (retire_valid) begin
        if (exp_q.size() == 0) begin
          $display("retire_valid went high with no instruction outstanding");
          $display("Test failed");
          $fatal(1);
        end else begin
          head = exp_q.pop_front();
          check_eq(cycle, head.cyc, "retire cycle");
          check_eq(retire_pc, head.pc, "retire_pc");
          check_eq(retire_illegal, head.illegal, "retire_illegal");
          check_eq(retire_rd_wr, head.rd_wr, "retire_rd_wr");
          check_eq(branch_taken, head.taken, "branch_taken");
          if (head.rd_wr) begin
            check_eq(retire_rd, head.rd, "retire_rd");
            check_eq(retire_data, head.data, "retire_data");
          end
          if (head.taken)
            check_eq(branch_target, head.target, "branch_target");
          n_retired++;
        end
      end else begin
        check_eq(branch_taken, 1'b0, "branch_taken while idle");
        check_eq(retire_rd_wr, 1'b0, "retire_rd_wr while idle");
      end
    end
  end

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    inst      = '0;
    pc        = '0;
    rng_state = seed;
    for (int r = 0; r < 32; r++)
      model_rf[r] = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < n_inst; i++) begin
      if (xorshift32() % 8 == 0) begin
        @(posedge clk);
        #2;
        in_valid = 1'b0;
      end
      @(posedge clk);
      #2;
      in_valid    = 1'b1;
      inst        = make_inst(i[4]);
      pc[63:32]   = xorshift32();
      pc[31:0]    = xorshift32() & ~32'd3;
      issued      = execute_ref(inst, pc);
      issued.cyc  = cycle + 2;
      exp_q.push_back(issued);
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    wait (n_retired == n_inst);
    repeat (2) @(negedge clk);
    check_eq(instret, n_inst, "final instret");
    $display("Test passed");
    $finish;
  end

endmodule
